// ==== src/snd_pkg.sv ====
//------------------------------------------------------------
// Sound board shared types
// Bus structs, sample widths, ROM banking schemes and
// the fixed mixer gains
//------------------------------------------------------------
package snd_pkg;

    typedef logic [15:0]        cpu_addr_t;
    typedef logic [7:0]         cpu_data_t;
    typedef logic [18:0]        rom_addr_t;
    typedef logic signed [15:0] fm_sample_t;
    typedef logic signed [8:0]  pcm_sample_t;
    typedef logic [7:0]         gain_t;      // 4.4 fixed point

    // Request from the sound CPU, io set for port cycles
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        logic      io;
        cpu_addr_t adr;
        cpu_data_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic      ack;
        cpu_data_t dat_r;
    } wb_rsp_t;

    // Board variants of the program ROM banking
    typedef enum logic [1:0] {
        bank_linear,
        bank_swapped,
        bank_onehot
    } bank_scheme_t;

    typedef struct packed {
        logic [5:0] rom_msb;
        logic       pcm_rst;
        logic       pcm_mdn;   // Low selects slave mode
    } ctrl_latch_t;

    localparam gain_t fm_gain_on = 8'h0C;   // 0.75

    // Indexed by fxlevel
    localparam gain_t [3:0] pcm_gain_table = {8'h18, 8'h0C, 8'h06, 8'h03};

    localparam rom_addr_t rom_bank_base = 19'h10000;

endpackage

// ==== src/snd_bus_decode.sv ====
//------------------------------------------------------------
// Sound CPU bus decoder
// Wishbone slave for memory and port cycles, owns the
// control latch and drives the chip and mailbox strobes
//------------------------------------------------------------
`timescale 1ns/100ps

module snd_bus_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  snd_pkg::wb_req_t     wb_req,
    output snd_pkg::wb_rsp_t     wb_rsp,
    output snd_pkg::ctrl_latch_t ctrl,
    output logic                 bank_sel,
    output logic                 rom_cs,
    input  snd_pkg::cpu_data_t   rom_data,
    input  logic                 rom_ok,
    output logic                 ram_we,
    input  snd_pkg::cpu_data_t   ram_dout,
    output logic                 fm_wr,
    output logic                 fm_a0,
    output snd_pkg::cpu_data_t   fm_din,
    input  snd_pkg::cpu_data_t   fm_dout,
    output logic                 pcm_wr,
    output snd_pkg::cpu_data_t   pcm_din,
    input  logic                 pcm_busyn,
    output logic                 mapper_rd,
    output logic                 mapper_wr,
    output snd_pkg::cpu_data_t   mapper_din,
    input  snd_pkg::cpu_data_t   mapper_dout
);
    import snd_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_decode,
        st_rom_wait,
        st_respond
    } state_t;

    state_t    state;
    logic      req_on;
    logic      sel_rom, sel_ram, sel_mbox, sel_fm, sel_ctrl, sel_pcm;
    logic      ack;
    cpu_data_t dat_r;
    cpu_data_t rd_mux;

    assign req_on = wb_req.cyc && wb_req.stb;

    // Memory map
    assign bank_sel = !wb_req.io && wb_req.adr[15:12] >= 4'h8 && wb_req.adr[15:12] < 4'hE;
    assign sel_rom  = !wb_req.io && (!wb_req.adr[15] || bank_sel);
    assign sel_ram  = !wb_req.io && wb_req.adr[15:11] == 5'b11111;

    // Port map on A7:A6, mailbox also at E800 in memory space
    assign sel_fm   = wb_req.io && wb_req.adr[7:6] == 2'd0;
    assign sel_ctrl = wb_req.io && wb_req.adr[7:6] == 2'd1;
    assign sel_pcm  = wb_req.io && wb_req.adr[7:6] == 2'd2;
    assign sel_mbox = wb_req.io ? wb_req.adr[7:6] == 2'd3 : wb_req.adr[15:11] == 5'b11101;

    // Chip data buses follow the held request
    assign fm_a0      = wb_req.adr[0];
    assign fm_din     = wb_req.dat_w;
    assign pcm_din    = wb_req.dat_w;
    assign mapper_din = wb_req.dat_w;

    // RAM sees the address during decode, data ready by respond
    assign ram_we = state == st_decode && sel_ram && wb_req.we;

    always_comb begin
        if (sel_ram)       rd_mux = ram_dout;
        else if (sel_fm)   rd_mux = fm_dout;
        else if (sel_pcm)  rd_mux = {pcm_busyn, 7'h7F};
        else if (sel_mbox) rd_mux = mapper_dout;
        else               rd_mux = 8'hFF;    // Unmapped
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            ack       <= 1'b0;
            rom_cs    <= 1'b0;
            fm_wr     <= 1'b0;
            pcm_wr    <= 1'b0;
            mapper_rd <= 1'b0;
            mapper_wr <= 1'b0;
        end else begin
            ack       <= 1'b0;
            fm_wr     <= 1'b0;
            pcm_wr    <= 1'b0;
            mapper_rd <= 1'b0;
            mapper_wr <= 1'b0;
            case (state)
                st_idle: begin
                    if (req_on && !ack) state <= st_decode;   // Skip the acked cycle
                end
                st_decode: begin
                    if (sel_rom && !wb_req.we) begin
                        rom_cs <= 1'b1;
                        state  <= st_rom_wait;
                    end else begin
                        state <= st_respond;
                    end
                end
                st_rom_wait: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        ack    <= 1'b1;
                        state  <= st_idle;
                    end
                end
                st_respond: begin
                    ack       <= 1'b1;
                    fm_wr     <= sel_fm && wb_req.we;
                    pcm_wr    <= sel_pcm && wb_req.we;
                    mapper_rd <= sel_mbox && !wb_req.we;
                    mapper_wr <= sel_mbox && wb_req.we;
                    state     <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_rom_wait && rom_ok) dat_r <= rom_data;
        else if (state == st_respond)       dat_r <= rd_mux;
    end

    // Control latch, bits 7:6 are active low on the bus
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl <= '{rom_msb: 6'd0, pcm_rst: 1'b1, pcm_mdn: 1'b1};
        end else if (state == st_respond && sel_ctrl && wb_req.we) begin
            ctrl <= '{rom_msb: wb_req.dat_w[5:0],
                      pcm_rst: ~wb_req.dat_w[6],
                      pcm_mdn: ~wb_req.dat_w[7]};
        end
    end

    assign wb_rsp = '{ack: ack, dat_r: dat_r};

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_rsp.ack) |-> wb_req.cyc && wb_req.stb);

    a_one_target: assert property (@(posedge clk) disable iff (rst)
        req_on |-> $onehot0({sel_rom, sel_ram, sel_mbox, sel_fm, sel_ctrl, sel_pcm}));

endmodule

// ==== src/snd_bank_map.sv ====
//------------------------------------------------------------
// Program ROM bank mapper
// Builds the 19-bit ROM address from the CPU address and
// the latched bank bits, per board banking scheme
//------------------------------------------------------------
`timescale 1ns/100ps

module snd_bank_map (
    input  logic               clk,
    input  logic               rst,
    input  snd_pkg::cpu_addr_t adr,
    input  logic               bank_sel,
    input  logic [5:0]         rom_msb,
    input  logic [7:0]         game_id,
    output snd_pkg::rom_addr_t rom_addr
);
    import snd_pkg::*;

    bank_scheme_t scheme;
    rom_addr_t    addr_n;

    always_comb begin
        casez (game_id[7:3])
            5'b001??: scheme = bank_swapped;
            5'b0001?: scheme = bank_onehot;
            default:  scheme = bank_linear;
        endcase
    end

    always_comb begin
        addr_n = {4'd0, adr[14:0]};    // Fixed area as is
        if (bank_sel) begin
            case (scheme)
                bank_swapped: addr_n[18:14] = {rom_msb[3], rom_msb[4], rom_msb[2:0]};
                bank_onehot: begin
                    addr_n[15:14] = rom_msb[1:0];
                    // Bit position of the one ROM enabled low
                    case (rom_msb[5:2])
                        4'b0111: addr_n[17:16] = 2'd3;
                        4'b1011: addr_n[17:16] = 2'd2;
                        4'b1101: addr_n[17:16] = 2'd1;
                        default: addr_n[17:16] = 2'd0;
                    endcase
                end
                default: addr_n[17:14] = rom_msb[3:0];
            endcase
            addr_n = addr_n + rom_bank_base;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) rom_addr <= '0;
        else     rom_addr <= addr_n;
    end

endmodule

// ==== src/snd_work_ram.sv ====
//------------------------------------------------------------
// Sound CPU work RAM
// Single port, synchronous read with one cycle latency
//------------------------------------------------------------
`timescale 1ns/100ps

module snd_work_ram #(
    parameter int ram_aw = 11
) (
    input  logic               clk,
    input  logic [ram_aw-1:0]  adr,
    input  logic               we,
    input  snd_pkg::cpu_data_t din,
    output snd_pkg::cpu_data_t dout
);
    import snd_pkg::*;

    cpu_data_t mem [2**ram_aw];

    always_ff @(posedge clk) begin
        if (we) mem[adr] <= din;
        dout <= mem[adr];    // Old data on a write cycle
    end

endmodule

// ==== src/snd_pole_filter.sv ====
//------------------------------------------------------------
// One-pole low-pass filter for the PCM voice
// Steps toward the input by (16 - a)/16 on each sample
//------------------------------------------------------------
`timescale 1ns/100ps

module snd_pole_filter #(
    parameter int pole_a = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample,
    input  snd_pkg::pcm_sample_t sin,
    output snd_pkg::pcm_sample_t sout
);
    localparam logic signed [5:0] coef = 6'(16 - pole_a);

    logic signed [12:0] acc;      // Four fraction bits
    logic signed [12:0] target;
    logic signed [13:0] diff;
    logic signed [19:0] prod;
    logic signed [19:0] acc_n;

    assign target = {sin, 4'b0000};
    assign diff   = target - acc;
    assign prod   = diff * coef;
    assign acc_n  = acc + (prod >>> 4);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)         acc <= '0;
        else if (sample) acc <= acc_n[12:0];
    end

    assign sout = acc[12:4];

    // Never overshoots the input
    a_no_overshoot: assert property (@(posedge clk) disable iff (rst)
        sample |=> (sout >= $past(sout) && sout <= $past(sin))
                || (sout <= $past(sout) && sout >= $past(sin)));

endmodule

// ==== src/snd_mixer.sv ====
//------------------------------------------------------------
// FM and PCM mixer
// Gain stage, then sum with saturation to 16 bits;
// peak marks the clipped samples
//------------------------------------------------------------
`timescale 1ns/100ps

module snd_mixer (
    input  logic                 clk,
    input  logic                 rst,
    input  snd_pkg::fm_sample_t  fm_left,
    input  snd_pkg::fm_sample_t  fm_right,
    input  snd_pkg::pcm_sample_t pcm,
    input  logic                 enable_fm,
    input  logic                 enable_pcm,
    input  logic [1:0]           fxlevel,
    output snd_pkg::fm_sample_t  snd,
    output logic                 peak
);
    import snd_pkg::*;

    localparam logic signed [26:0] pos_lim = 27'sd32767;
    localparam logic signed [26:0] neg_lim = -27'sd32768;

    gain_t              fm_gain;
    gain_t              pcm_gain;
    fm_sample_t         pcm_wide;
    logic signed [24:0] prod_l, prod_r, prod_p;
    logic signed [26:0] sum;
    logic signed [26:0] scaled;
    fm_sample_t         level;
    logic               clip;

    assign fm_gain  = enable_fm ? fm_gain_on : '0;
    assign pcm_gain = enable_pcm ? pcm_gain_table[fxlevel] : '0;
    assign pcm_wide = {pcm, 7'd0};    // Up to FM scale

    // Gain stage, gains are unsigned
    always_ff @(posedge clk) begin
        prod_l <= fm_left * $signed({1'b0, fm_gain});
        prod_r <= fm_right * $signed({1'b0, fm_gain});
        prod_p <= pcm_wide * $signed({1'b0, pcm_gain});
    end

    assign sum    = prod_l + prod_r + prod_p;
    assign scaled = sum >>> 4;    // Drop the 4.4 fraction

    always_comb begin
        clip  = 1'b0;
        level = scaled[15:0];
        if (scaled > pos_lim) begin
            level = 16'sh7FFF;
            clip  = 1'b1;
        end else if (scaled < neg_lim) begin
            level = 16'sh8000;
            clip  = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd  <= '0;
            peak <= 1'b0;
        end else begin
            snd  <= level;
            peak <= clip;
        end
    end

endmodule

// ==== src/snd_board.sv ====
//------------------------------------------------------------
// Sound board glue and audio path
// Bus decode, ROM banking, work RAM, PCM filter and mixer
//------------------------------------------------------------
`timescale 1ns/100ps

module snd_board #(
    parameter int pole_a = 10,
    parameter int ram_aw = 11
) (
    input  logic                 clk,
    input  logic                 rst,
    input  snd_pkg::wb_req_t     wb_req,
    output snd_pkg::wb_rsp_t     wb_rsp,
    input  logic [7:0]           game_id,
    output snd_pkg::rom_addr_t   rom_addr,
    output logic                 rom_cs,
    input  snd_pkg::cpu_data_t   rom_data,
    input  logic                 rom_ok,
    output logic                 fm_wr,
    output logic                 fm_a0,
    output snd_pkg::cpu_data_t   fm_din,
    input  snd_pkg::cpu_data_t   fm_dout,
    output logic                 pcm_wr,
    output snd_pkg::cpu_data_t   pcm_din,
    input  logic                 pcm_busyn,
    output logic                 pcm_rst,
    output logic                 pcm_mdn,
    output logic                 mapper_rd,
    output logic                 mapper_wr,
    output snd_pkg::cpu_data_t   mapper_din,
    input  snd_pkg::cpu_data_t   mapper_dout,
    input  snd_pkg::fm_sample_t  fm_left,
    input  snd_pkg::fm_sample_t  fm_right,
    input  snd_pkg::pcm_sample_t pcm_raw,
    input  logic                 sample,
    input  logic                 enable_fm,
    input  logic                 enable_pcm,
    input  logic [1:0]           fxlevel,
    output snd_pkg::fm_sample_t  snd,
    output logic                 snd_sample,
    output logic                 peak
);
    import snd_pkg::*;

    ctrl_latch_t ctrl;
    logic        bank_sel;
    logic        ram_we;
    cpu_data_t   ram_dout;
    pcm_sample_t pcm_snd;

    assign pcm_rst    = ctrl.pcm_rst;
    assign pcm_mdn    = ctrl.pcm_mdn;
    assign snd_sample = sample;    // FM chip sets the sample rate

    snd_bus_decode i_decode (
        .clk         (clk),
        .rst         (rst),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .ctrl        (ctrl),
        .bank_sel    (bank_sel),
        .rom_cs      (rom_cs),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .ram_we      (ram_we),
        .ram_dout    (ram_dout),
        .fm_wr       (fm_wr),
        .fm_a0       (fm_a0),
        .fm_din      (fm_din),
        .fm_dout     (fm_dout),
        .pcm_wr      (pcm_wr),
        .pcm_din     (pcm_din),
        .pcm_busyn   (pcm_busyn),
        .mapper_rd   (mapper_rd),
        .mapper_wr   (mapper_wr),
        .mapper_din  (mapper_din),
        .mapper_dout (mapper_dout)
    );

    snd_bank_map i_bank_map (
        .clk      (clk),
        .rst      (rst),
        .adr      (wb_req.adr),
        .bank_sel (bank_sel),
        .rom_msb  (ctrl.rom_msb),
        .game_id  (game_id),
        .rom_addr (rom_addr)
    );

    snd_work_ram #(.ram_aw(ram_aw)) i_work_ram (
        .clk  (clk),
        .adr  (wb_req.adr[ram_aw-1:0]),
        .we   (ram_we),
        .din  (wb_req.dat_w),
        .dout (ram_dout)
    );

    snd_pole_filter #(.pole_a(pole_a)) i_pole_filter (
        .clk    (clk),
        .rst    (rst),
        .sample (sample),
        .sin    (pcm_raw),
        .sout   (pcm_snd)
    );

    snd_mixer i_mixer (
        .clk        (clk),
        .rst        (rst),
        .fm_left    (fm_left),
        .fm_right   (fm_right),
        .pcm        (pcm_snd),
        .enable_fm  (enable_fm),
        .enable_pcm (enable_pcm),
        .fxlevel    (fxlevel),
        .snd        (snd),
        .peak       (peak)
    );

endmodule

// ==== bench/snd_board_tb.sv ====
//------------------------------------------------------------
// Sound board testbench
// Wishbone master, ROM and mailbox models, FM and PCM
// sample stimulus with assertion based checking
//------------------------------------------------------------
`timescale 1ns/100ps

module snd_board_tb;
    import snd_pkg::*;

    logic clk = 1'b0;
    logic rst = 1'b1;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic [7:0] game_id;
    rom_addr_t rom_addr, exp_rom;
    logic rom_cs, rom_ok, rom_chk;
    cpu_data_t rom_data, fm_din, pcm_din, mapper_din, fm_last, pcm_last, mw_last;
    logic fm_wr, fm_a0, fm_a0_last, pcm_wr, pcm_busyn, pcm_rst, pcm_mdn, mapper_rd, mapper_wr;
    fm_sample_t fm_left, fm_right, snd;
    pcm_sample_t pcm_raw;
    logic sample, enable_fm, enable_pcm, snd_sample, peak, pcm_check_on;
    logic [1:0] fxlevel;
    int errors, timeouts, rom_delay, rom_lat, fm_cnt, pcm_cnt, mw_cnt, mr_cnt;

    always #5 clk = ~clk;

    snd_board #(.pole_a(10), .ram_aw(11)) i_dut (
        .clk(clk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp), .game_id(game_id),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
        .fm_wr(fm_wr), .fm_a0(fm_a0), .fm_din(fm_din), .fm_dout(8'h3C),
        .pcm_wr(pcm_wr), .pcm_din(pcm_din), .pcm_busyn(pcm_busyn),
        .pcm_rst(pcm_rst), .pcm_mdn(pcm_mdn), .mapper_rd(mapper_rd), .mapper_wr(mapper_wr),
        .mapper_din(mapper_din), .mapper_dout(8'h5A), .fm_left(fm_left), .fm_right(fm_right),
        .pcm_raw(pcm_raw), .sample(sample), .enable_fm(enable_fm), .enable_pcm(enable_pcm),
        .fxlevel(fxlevel), .snd(snd), .snd_sample(snd_sample), .peak(peak)
    );

    // ROM content depends on every address bit
    function automatic cpu_data_t rom_byte(rom_addr_t a);
        return a[7:0] ^ a[15:8] ^ {a[18:16], a[18:16], a[17:16]} ^ 8'hA5;
    endfunction

    function automatic rom_addr_t predict_rom(cpu_addr_t adr, logic [5:0] msb, logic [7:0] gid);
        rom_addr_t a;
        int zeros;
        int pos;
        a = {4'd0, adr[14:0]};
        zeros = 0;
        pos = 0;
        if (adr[15]) begin
            if (gid[7:5] == 3'b001) begin
                a[18:14] = {msb[3], msb[4], msb[2:0]};
            end else if (gid[7:4] == 4'b0001) begin
                a[15:14] = msb[1:0];
                for (int i = 0; i < 4; i++) begin
                    if (!msb[2+i]) begin
                        zeros++;
                        pos = i;
                    end
                end
                a[17:16] = (zeros == 1) ? pos[1:0] : 2'd0;
            end else begin
                a[17:14] = msb[3:0];
            end
            a = a + 19'h10000;
        end
        return a;
    endfunction

    task automatic check_eq(input string name, input longint got, input longint exp);
        assert (got == exp) else begin
            errors++;
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // ROM model with the latency drawn by the bus master
    always @(posedge clk) begin
        rom_ok <= 1'b0;
        if (rom_cs && !rom_ok) begin
            if (rom_delay == 0) begin
                rom_delay = rom_lat;
            end else if (rom_delay == 1) begin
                rom_ok    <= 1'b1;
                rom_data  <= rom_byte(rom_addr);
                rom_delay = 0;
            end else begin
                rom_delay--;
            end
        end
    end

    task automatic count_strobes();
        if (fm_wr) begin
            fm_cnt++;
            fm_last    = fm_din;
            fm_a0_last = fm_a0;
        end
        if (pcm_wr) begin
            pcm_cnt++;
            pcm_last = pcm_din;
        end
        if (mapper_wr) begin
            mw_cnt++;
            mw_last = mapper_din;
        end
        if (mapper_rd) mr_cnt++;
        if (rom_chk && rom_cs) check_eq("rom_addr", rom_addr, exp_rom);
    endtask

    // One Wishbone classic cycle with lat counted in edges from the drive edge
    task automatic bus_cycle(input logic io, input logic we, input cpu_addr_t adr,
                             input cpu_data_t dat, output cpu_data_t rdata, output int lat);
        int n;
        n = 0;
        fm_cnt = 0;
        pcm_cnt = 0;
        mw_cnt = 0;
        mr_cnt = 0;
        rom_lat = $urandom_range(6, 1);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, io: io, adr: adr, dat_w: dat};
        do begin
            @(posedge clk);
            n++;
            count_strobes();
        end while (!wb_rsp.ack && n < 40);
        if (!wb_rsp.ack) begin
            $display("Timeout: no ack for the cycle at address %h", adr);
            timeouts++;
        end
        rdata = wb_rsp.dat_r;
        lat = n;
        wb_req <= '0;
        @(posedge clk);
        count_strobes();
    endtask

    task automatic wait_edges(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic finish_run();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    a_ack_pulse: assert property (@(posedge clk) disable iff (rst) wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            errors++;
            $display("ack held high for more than one cycle");
        end

    a_rom_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(rom_cs) |-> wb_rsp.ack && $past(rom_ok))
        else begin
            errors++;
            $display("ROM fetch ended without rom_ok and ack");
        end

    a_strobe_pulse: assert property (@(posedge clk) disable iff (rst)
        (fm_wr || pcm_wr || mapper_wr || mapper_rd)
        |=> !(fm_wr || pcm_wr || mapper_wr || mapper_rd))
        else begin
            errors++;
            $display("Strobe held high for more than one cycle");
        end

    a_sample_out: assert property (@(posedge clk) disable iff (rst) snd_sample == sample)
        else begin
            errors++;
            $display("[FAIL] %0t snd_sample: got %0b, expected %0b", $time, snd_sample, sample);
        end

    // Filter output reaches snd three edges after a strobe
    a_snd_hold: assert property (@(posedge clk) disable iff (rst || !pcm_check_on)
        $changed(snd) |-> $past(sample, 3))
        else begin
            errors++;
            $display("snd changed without a sample strobe");
        end

    initial begin
        cpu_data_t ram_model [cpu_addr_t];
        cpu_addr_t a;
        cpu_data_t d, r;
        int lat;
        longint s, g, c;
        logic [7:0] gids [3];
        int gains [4];
        void'($urandom(51198));
        gids = '{8'h00, 8'h28, 8'h10};
        gains = '{3, 6, 12, 24};
        wb_req = '0;
        game_id = 8'h00;
        rom_ok = 1'b0;
        rom_data = '0;
        rom_chk = 1'b0;
        exp_rom = '0;
        pcm_busyn = 1'b1;
        fm_left = '0;
        fm_right = '0;
        pcm_raw = '0;
        sample = 1'b0;
        enable_fm = 1'b0;
        enable_pcm = 1'b0;
        fxlevel = 2'd0;
        pcm_check_on = 1'b0;
        errors = 0;
        timeouts = 0;
        rom_delay = 0;
        rom_lat = 1;
        wait_edges(8);
        rst <= 1'b0;
        wait_edges(2);

        check_eq("pcm_rst", pcm_rst, 1);
        check_eq("pcm_mdn", pcm_mdn, 1);

        // Work RAM request seen on edge 1 and acked 2 edges later
        for (int i = 0; i < 16; i++) begin
            a = 16'hF800 + 16'($urandom_range(16'h07FF, 0));
            d = 8'($urandom);
            ram_model[a] = d;
            bus_cycle(1'b0, 1'b1, a, d, r, lat);
            check_eq("ram write latency", lat, 4);
        end
        foreach (ram_model[k]) begin
            bus_cycle(1'b0, 1'b0, k, 8'h00, r, lat);
            check_eq("ram dat_r", r, ram_model[k]);
            check_eq("ram read latency", lat, 4);
        end

        // Fixed ROM
        rom_chk = 1'b1;
        for (int i = 0; i < 8; i++) begin
            a = 16'($urandom_range(16'h7FFF, 0));
            exp_rom = {4'd0, a[14:0]};
            bus_cycle(1'b0, 1'b0, a, 8'h00, r, lat);
            check_eq("fixed rom dat_r", r, rom_byte(exp_rom));
        end

        // Banked ROM per scheme
        foreach (gids[j]) begin
            game_id <= gids[j];
            for (int i = 0; i < 8; i++) begin
                d = 8'($urandom);
                if (i[0]) d[5:2] = ~(4'b0001 << $urandom_range(3, 0));    // Single zero
                rom_chk = 1'b0;
                bus_cycle(1'b1, 1'b1, 16'h0040, d, r, lat);
                rom_chk = 1'b1;
                a = 16'h8000 + 16'($urandom_range(16'h5FFF, 0));
                exp_rom = predict_rom(a, d[5:0], gids[j]);
                bus_cycle(1'b0, 1'b0, a, 8'h00, r, lat);
                check_eq("banked rom dat_r", r, rom_byte(exp_rom));
            end
        end
        rom_chk = 1'b0;

        // Port writes pulse one strobe each
        d = 8'($urandom);
        bus_cycle(1'b1, 1'b1, 16'h0001, d, r, lat);
        check_eq("fm_wr count", fm_cnt, 1);
        check_eq("other strobes on fm write", pcm_cnt + mw_cnt + mr_cnt, 0);
        check_eq("fm_din", fm_last, d);
        check_eq("fm_a0", fm_a0_last, 1);
        d = 8'($urandom);
        bus_cycle(1'b1, 1'b1, 16'h0080, d, r, lat);
        check_eq("pcm_wr count", pcm_cnt, 1);
        check_eq("other strobes on pcm write", fm_cnt + mw_cnt + mr_cnt, 0);
        check_eq("pcm_din", pcm_last, d);
        d = 8'($urandom);
        bus_cycle(1'b1, 1'b1, 16'h0040, d, r, lat);
        check_eq("strobes on ctrl write", fm_cnt + pcm_cnt + mw_cnt + mr_cnt, 0);
        check_eq("pcm_rst", pcm_rst, !d[6]);
        check_eq("pcm_mdn", pcm_mdn, !d[7]);
        foreach (gids[j]) begin
            a = (j == 0) ? 16'hE800 : 16'h00C0;    // Memory and port mailbox
            d = 8'($urandom);
            bus_cycle(j != 0, 1'b1, a, d, r, lat);
            check_eq("mapper_wr count", mw_cnt, 1);
            check_eq("other strobes on mailbox write", fm_cnt + pcm_cnt + mr_cnt, 0);
            check_eq("mapper_din", mw_last, d);
            bus_cycle(j != 0, 1'b0, a, 8'h00, r, lat);
            check_eq("mapper_rd count", mr_cnt, 1);
            check_eq("mailbox dat_r", r, 8'h5A);
        end
        for (int i = 0; i < 2; i++) begin
            pcm_busyn <= i[0];
            bus_cycle(1'b1, 1'b0, 16'h0080, 8'h00, r, lat);
            check_eq("pcm status dat_r", r, {i[0], 7'h7F});
        end
        bus_cycle(1'b0, 1'b0, 16'hE000, 8'h00, r, lat);
        check_eq("unmapped dat_r", r, 8'hFF);
        bus_cycle(1'b0, 1'b0, 16'hF000, 8'h00, r, lat);
        check_eq("unmapped dat_r", r, 8'hFF);

        // FM mixing with full scale first to force clipping
        enable_fm <= 1'b1;
        for (int i = 0; i < 24; i++) begin
            if (i < 2) begin
                fm_left  <= i ? -16'sd32768 : 16'sd32767;
                fm_right <= i ? -16'sd32768 : 16'sd32767;
                s = i ? -65536 : 65534;
            end else begin
                fm_left  <= 16'($urandom);
                fm_right <= 16'($urandom);
                wait_edges(1);
                s = longint'(fm_left) + longint'(fm_right);
            end
            wait_edges(i < 2 ? 3 : 2);
            s = (s * 12) >>> 4;
            check_eq("peak", peak, s > 32767 || s < -32768);
            if (s > 32767) s = 32767;
            else if (s < -32768) s = -32768;
            check_eq("snd", snd, s);
        end

        // PCM through the filter with FM off
        enable_fm <= 1'b0;
        enable_pcm <= 1'b1;
        for (int lvl = 0; lvl < 4; lvl++) begin
            pcm_check_on = 1'b0;
            c = lvl[0] ? -170 : 150;
            fxlevel <= 2'(lvl);
            pcm_raw <= 9'(c);
            wait_edges(5);
            pcm_check_on = 1'b1;
            repeat (64) begin
                sample <= 1'b1;
                wait_edges(1);
                sample <= 1'b0;
                wait_edges(3);
            end
            wait_edges(4);
            g = gains[lvl];
            s = (c * 128 * g) >>> 4;
            // Two PCM steps of slack for the filter's truncation
            assert (snd - s <= 16 * g && s - snd <= 16 * g) else begin
                errors++;
                $display("[FAIL] %0t snd: got %0d, expected %0d", $time, snd, s);
            end
        end
        pcm_check_on = 1'b0;
        finish_run();
    end

endmodule

// ==== sim.f ====
src/snd_pkg.sv
src/snd_bus_decode.sv
src/snd_bank_map.sv
src/snd_work_ram.sv
src/snd_pole_filter.sv
src/snd_mixer.sv
src/snd_board.sv
bench/snd_board_tb.sv

// ==== Bender.yml ====
package:
  name: snd_board

sources:
  - src/snd_pkg.sv
  - src/snd_bus_decode.sv
  - src/snd_bank_map.sv
  - src/snd_work_ram.sv
  - src/snd_pole_filter.sv
  - src/snd_mixer.sv
  - src/snd_board.sv
  - target: test
    files:
      - bench/snd_board_tb.sv
